//--- verilog.f
n64a_video_pkg.sv
n64a_cfg_pkg.sv
n64_vinfo_ext.sv
n64_vdemux.sv
n64_vdemux_top.sv
tb_n64_vdemux.sv

//--- Makefile
# Verilator build and run for the video demux testbench

VERILATOR ?= verilator
TOP       ?= tb_n64_vdemux
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= === PASS ===

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit status is not used
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@if grep -q -- '$(PASS_MSG)' $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_n64_vdemux.sv
`timescale 1ns/1ps
`default_nettype none

module tb_n64_vdemux
  import n64a_video_pkg::*;
();

  localparam int clk_period      = 100;
  localparam int drive_skew      = 5;
  localparam int reset_cycles    = 8;
  localparam int n_lines         = 42;
  localparam int watchdog_cycles = n_lines * 4 + 20;

  // one entry per four word group as {sync nibble, vmode, ndeblur, n15bit}
  // sync nibble is active low {nvsync, nclamp, nhsync, ncsync}
  localparam logic [6:0] stim_tab [n_lines] = '{
    // full colour, deblur off, one hsync pulse
    {4'hf, 3'b011}, {4'hf, 3'b011}, {4'hf, 3'b011},
    {4'hc, 3'b011}, {4'hf, 3'b011}, {4'hf, 3'b011},
    // progressive vsync with hsync high at the edge
    {4'h6, 3'b011}, {4'h6, 3'b011}, {4'hf, 3'b011},
    // reduced colour waits for the vsync edge and so does the way back
    {4'hf, 3'b010}, {4'hf, 3'b010}, {4'h6, 3'b010}, {4'hf, 3'b010},
    {4'hf, 3'b011}, {4'h6, 3'b011}, {4'hf, 3'b011},
    // deblur on with csync restarting the pattern from vmode 1 and then 0
    // each csync rise lands where a plain toggle would give the other value
    {4'hf, 3'b101}, {4'hc, 3'b101}, {4'hf, 3'b101}, {4'hf, 3'b101},
    {4'hf, 3'b101}, {4'hf, 3'b101}, {4'hf, 3'b101},
    {4'hc, 3'b001}, {4'hf, 3'b001}, {4'hf, 3'b001}, {4'hf, 3'b001},
    {4'hf, 3'b011}, {4'hf, 3'b011},
    // hsync level alternates at vsync in 480i so deblur is overridden
    {4'h4, 3'b001}, {4'hf, 3'b001}, {4'hf, 3'b001}, {4'h6, 3'b001}, {4'hf, 3'b001},
    {4'h4, 3'b001}, {4'hf, 3'b001},
    // aligned edges clear the flag again
    {4'h4, 3'b001}, {4'hf, 3'b001}, {4'hf, 3'b001},
    // last group gets flushed by one more dsync
    {4'hf, 3'b011}, {4'hf, 3'b011}, {4'hf, 3'b011}
  };

  logic                   nclk_i;
  logic                   reset_i;
  logic                   dsync_i;
  logic [color_width-1:0] d_i;
  logic                   vmode_i;
  logic                   ndeblur_i;
  logic                   n15bit_i;
  wire  [vdata_width-1:0] vdata_o;
  wire                    vdata_valid_o;
  wire                    n64_480i_o;

  // reference model state
  logic [sync_width-1:0]     ref_sync;
  logic [vdata_co_width-1:0] ref_capt;
  logic                      ref_hs_low;
  logic                      ref_480i;
  logic                      ref_nblank;
  logic                      ref_n15bit;
  logic [vdata_width-1:0]    exp_vdata;
  int                        group_idx;

  n64_vdemux_top i_n64_vdemux_top (
    .nclk_i        (nclk_i),
    .reset_i       (reset_i),
    .dsync_i       (dsync_i),
    .d_i           (d_i),
    .vmode_i       (vmode_i),
    .ndeblur_i     (ndeblur_i),
    .n15bit_i      (n15bit_i),
    .vdata_o       (vdata_o),
    .vdata_valid_o (vdata_valid_o),
    .n64_480i_o    (n64_480i_o)
  );

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_vdata(input logic [vdata_width-1:0] got,
                             input logic [vdata_width-1:0] exp_v);
    if (got !== exp_v) begin
      abort_run($sformatf("FAIL %0t ns: group %0d vdata_o is %h, expected %h",
        $time, group_idx, got, exp_v));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp_v);
    if (got !== exp_v) begin
      abort_run($sformatf("FAIL %0t ns: group %0d vdata_valid_o is %b, expected %b",
        $time, group_idx, got, exp_v));
    end
  endtask

  task automatic check_480i(input logic got, input logic exp_v);
    if (got !== exp_v) begin
      abort_run($sformatf("FAIL %0t ns: group %0d n64_480i_o is %b, expected %b",
        $time, group_idx, got, exp_v));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // reduced mode clears the two low colour bits
  function automatic logic [color_width-1:0] reduce_color(input logic [color_width-1:0] c);
    if (ref_n15bit) begin
      return c;
    end
    return {c[color_width-1:2], 2'b00};
  endfunction

  // everything that happens on the falling edge that samples a dsync word
  task automatic predict_sync_edge(input logic [sync_width-1:0] sync, input logic [2:0] cfg);
    logic vs_fall;
    logic cs_rise;
    logic hs_low;
    vs_fall = ref_sync[sync_nvsync] & ~sync[sync_nvsync];
    cs_rise = ~ref_sync[sync_ncsync] & sync[sync_ncsync];
    hs_low  = ~sync[sync_nhsync];
    // previous group moves out, colour only on a passed pixel
    exp_vdata[vdata_sy_lsb +: sync_width] = ref_sync;
    if (ref_nblank) begin
      exp_vdata[vdata_bl_lsb +: vdata_co_width] = ref_capt;
    end
    // blanking uses the interlace flag from before this edge
    if (ref_480i || cfg[1]) begin
      ref_nblank = 1'b1;
    end else if (cs_rise) begin
      ref_nblank = cfg[2];
    end else begin
      ref_nblank = ~ref_nblank;
    end
    if (vs_fall) begin
      ref_n15bit = cfg[0];
      ref_480i   = hs_low ^ ref_hs_low;
      ref_hs_low = hs_low;
    end
    ref_sync = sync;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // drive one bus word after the rising edge, check after the falling edge
  task automatic run_cycle(input logic dsync, input logic [color_width-1:0] d,
                           input logic [2:0] cfg, input logic exp_valid);
    #(drive_skew);
    dsync_i   = dsync;
    d_i       = d;
    vmode_i   = cfg[2];
    ndeblur_i = cfg[1];
    n15bit_i  = cfg[0];
    @(posedge nclk_i);
    check_valid(vdata_valid_o, exp_valid);
    check_vdata(vdata_o, exp_vdata);
    check_480i(n64_480i_o, ref_480i);
  endtask

  task automatic apply_group(input logic [6:0] ent);
    logic [31:0]            rnd;
    logic [color_width-1:0] red;
    logic [color_width-1:0] green;
    logic [color_width-1:0] blue;
    logic [sync_width-1:0]  sync;
    logic [2:0]             cfg;
    sync  = ent[6:3];
    cfg   = ent[2:0];
    rnd   = $urandom;
    red   = rnd[6:0];
    green = rnd[13:7];
    blue  = rnd[20:14];
    predict_sync_edge(sync, cfg);
    // colour depth of this group is the one chosen at its own dsync edge
    ref_capt = {reduce_color(red), reduce_color(green), reduce_color(blue)};
    // strobe only right after the dsync edge
    run_cycle(1'b0, {{(color_width-sync_width){1'b0}}, sync}, cfg, 1'b1);
    run_cycle(1'b1, red, cfg, 1'b0);
    run_cycle(1'b1, green, cfg, 1'b0);
    run_cycle(1'b1, blue, cfg, 1'b0);
  endtask

  initial begin
    nclk_i = 1'b0;
    forever #(clk_period / 2) nclk_i = ~nclk_i;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    abort_run("watchdog timeout, the stimulus table did not finish in time");
  end

  initial begin
    void'($urandom(32'hba05));
    reset_i    = 1'b1;
    dsync_i    = 1'b1;
    d_i        = '0;
    vmode_i    = 1'b0;
    ndeblur_i  = 1'b1;
    n15bit_i   = 1'b1;
    ref_sync   = '0;
    ref_capt   = '0;
    ref_hs_low = 1'b0;
    ref_480i   = 1'b0;
    ref_nblank = 1'b1;
    ref_n15bit = 1'b1;
    exp_vdata  = '0;
    group_idx  = -1;
    repeat (reset_cycles) @(posedge nclk_i);
    // outputs cleared while reset is held
    check_valid(vdata_valid_o, 1'b0);
    check_vdata(vdata_o, exp_vdata);
    check_480i(n64_480i_o, 1'b0);
    #(drive_skew);
    reset_i = 1'b0;
    @(posedge nclk_i);
    check_valid(vdata_valid_o, 1'b0);
    check_vdata(vdata_o, exp_vdata);
    for (int i = 0; i < n_lines; i++) begin
      group_idx = i;
      apply_group(stim_tab[i]);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- n64_vdemux_top.sv
`timescale 1ns/1ps
`default_nettype none

module n64_vdemux_top
  import n64a_video_pkg::*;
  import n64a_cfg_pkg::*;
(
  input  wire                   nclk_i,
  input  wire                   reset_i,
  input  wire                   dsync_i,
  input  wire [color_width-1:0] d_i,
  // configuration
  input  wire                   vmode_i,
  input  wire                   ndeblur_i,
  input  wire                   n15bit_i,
  // parallel video out
  output wire [vdata_width-1:0] vdata_o,
  output wire                   vdata_valid_o,
  output wire                   n64_480i_o
);

  phase_t                       data_cnt;
  wire [demuxparams_width-1:0] demuxparams;

  ////////////////////////////////////////////////////////////////////
  // bus phase and video mode
  ////////////////////////////////////////////////////////////////////

  n64_vinfo_ext i_vinfo_ext (
    .nclk_i     (nclk_i),
    .reset_i    (reset_i),
    .dsync_i    (dsync_i),
    .d_i        (d_i),
    .data_cnt_o (data_cnt),
    .n64_480i_o (n64_480i_o)
  );

  // control bundle for the demux
  assign demuxparams[dp_cnt_lsb +: dp_cnt_width] = data_cnt;
  assign demuxparams[dp_480i]                    = n64_480i_o;
  assign demuxparams[dp_vmode]                   = vmode_i;
  assign demuxparams[dp_ndeblur]                 = ndeblur_i;
  assign demuxparams[dp_n15bit]                  = n15bit_i;

  ////////////////////////////////////////////////////////////////////
  // demux
  ////////////////////////////////////////////////////////////////////

  n64_vdemux i_vdemux (
    .nclk_i        (nclk_i),
    .reset_i       (reset_i),
    .dsync_i       (dsync_i),
    .d_i           (d_i),
    .demuxparams_i (demuxparams),
    .vdata_o       (vdata_o),
    .vdata_valid_o (vdata_valid_o)
  );

endmodule

`default_nettype wire

//--- n64_vdemux.sv
`timescale 1ns/1ps
`default_nettype none

module n64_vdemux
  import n64a_video_pkg::*;
  import n64a_cfg_pkg::*;
(
  input  wire                         nclk_i,
  input  wire                         reset_i,
  input  wire                         dsync_i,
  input  wire [color_width-1:0]       d_i,
  input  wire [demuxparams_width-1:0] demuxparams_i,
  output logic [vdata_width-1:0]      vdata_o,
  output logic                        vdata_valid_o
);

  ////////////////////////////////////////////////////////////////////
  // control bundle unpack
  ////////////////////////////////////////////////////////////////////

  phase_t data_cnt;
  assign data_cnt = phase_t'(demuxparams_i[dp_cnt_lsb +: dp_cnt_width]);

  wire n64_480i = demuxparams_i[dp_480i];
  wire vmode    = demuxparams_i[dp_vmode];
  wire ndeblur  = demuxparams_i[dp_ndeblur];

  // n15bit is taken per frame and not straight from the bundle
  logic n15bit_mode;
  // high when the current pixel may update the colour output
  logic nblank_rgb;

  // group being collected {sync, red, green, blue}
  logic [vdata_width-1:0] capt_q;

  // sync word of the previous group against the one on the bus
  wire capt_nvsync = capt_q[vdata_sy_lsb + sync_nvsync];
  wire capt_ncsync = capt_q[vdata_sy_lsb + sync_ncsync];
  wire vsync_fall  = capt_nvsync & ~d_i[sync_nvsync];
  wire csync_rise  = ~capt_ncsync & d_i[sync_ncsync];

  // reduced mode keeps the upper five bits only
  wire [color_width-1:0] color_in = n15bit_mode ? d_i :
    {d_i[color_width-1:reduced_lsbs], {reduced_lsbs{1'b0}}};

  ////////////////////////////////////////////////////////////////////
  // colour mode and deblur blanking
  ////////////////////////////////////////////////////////////////////

  // new frame, new colour depth
  always_ff @(negedge nclk_i) begin
    if (reset_i) begin
      n15bit_mode <= n15bit_rst;
    end else if (!dsync_i && vsync_fall) begin
      n15bit_mode <= demuxparams_i[dp_n15bit];
    end
  end

  // deblur drops every other pixel of a progressive line
  // each csync rising edge restarts the pattern from vmode
  always_ff @(negedge nclk_i) begin
    if (reset_i) begin
      nblank_rgb <= nblank_pass;
    end else if (!dsync_i) begin
      if (n64_480i || ndeblur) begin
        nblank_rgb <= nblank_pass;
      end else if (csync_rise) begin
        nblank_rgb <= vmode;
      end else begin
        nblank_rgb <= ~nblank_rgb;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // capture and output registers
  ////////////////////////////////////////////////////////////////////

  // sync on the dsync word, then one colour per phase
  always_ff @(negedge nclk_i) begin
    if (reset_i) begin
      capt_q <= '0;
    end else if (!dsync_i) begin
      capt_q[vdata_sy_lsb +: sync_width] <= d_i[sync_width-1:0];
    end else begin
      case (data_cnt)
        phase_red:   capt_q[vdata_re_lsb +: color_width] <= color_in;
        phase_green: capt_q[vdata_gr_lsb +: color_width] <= color_in;
        phase_blue:  capt_q[vdata_bl_lsb +: color_width] <= color_in;
        default: ;
      endcase
    end
  end

  // finished group moves out at the dsync edge of the next one
  // sync always follows while colour holds on a blanked pixel
  always_ff @(negedge nclk_i) begin
    if (reset_i) begin
      vdata_o       <= '0;
      vdata_valid_o <= 1'b0;
    end else begin
      // strobe marks the cycle right after the transfer
      vdata_valid_o <= ~dsync_i;
      if (!dsync_i) begin
        vdata_o[vdata_sy_lsb +: sync_width] <= capt_q[vdata_sy_lsb +: sync_width];
        if (nblank_rgb) begin
          vdata_o[vdata_bl_lsb +: vdata_co_width] <=
            capt_q[vdata_bl_lsb +: vdata_co_width];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- n64_vinfo_ext.sv
`timescale 1ns/1ps
`default_nettype none

module n64_vinfo_ext
  import n64a_video_pkg::*;
(
  input  wire                   nclk_i,
  input  wire                   reset_i,
  input  wire                   dsync_i,
  input  wire [color_width-1:0] d_i,
  output phase_t                data_cnt_o,
  output logic                  n64_480i_o
);

  ////////////////////////////////////////////////////////////////////
  // sync word decode
  ////////////////////////////////////////////////////////////////////

  // nvsync seen on the previous dsync word
  logic nvsync_q;
  // nhsync was low at the last vsync falling edge
  logic hs_low_q;

  wire nvsync_now = d_i[sync_nvsync];
  wire hs_low_now = ~d_i[sync_nhsync];

  // falling nvsync between two consecutive sync words
  // only meaningful while dsync_i is low
  wire vs_fall = nvsync_q & ~nvsync_now;

  ////////////////////////////////////////////////////////////////////
  // data phase counter
  ////////////////////////////////////////////////////////////////////

  // dsync word restarts the count so that the red word sees phase 1
  // and the count then labels green and blue on the next two edges
  always_ff @(negedge nclk_i) begin
    if (reset_i) begin
      data_cnt_o <= phase_sync;
    end else if (!dsync_i) begin
      data_cnt_o <= phase_red;
    end else begin
      // wraps back to sync after blue when no dsync arrives
      data_cnt_o <= phase_t'(data_cnt_o + 2'd1);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // interlace detector
  ////////////////////////////////////////////////////////////////////

  // in progressive video vsync always falls at the same hsync level
  // in 480i the two fields put the vsync edge half a line apart
  // so the hsync level at the edge alternates frame by frame
  always_ff @(negedge nclk_i) begin
    if (reset_i) begin
      nvsync_q   <= 1'b0;
      hs_low_q   <= 1'b0;
      n64_480i_o <= 1'b0;
    end else if (!dsync_i) begin
      nvsync_q <= nvsync_now;
      if (vs_fall) begin
        // remember this frame and compare with the last one
        hs_low_q   <= hs_low_now;
        n64_480i_o <= hs_low_now ^ hs_low_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- n64a_cfg_pkg.sv
`default_nettype none

package n64a_cfg_pkg;

  ////////////////////////////////////////////////////////////////////
  // demux control bundle
  ////////////////////////////////////////////////////////////////////

  // {data_cnt[1:0], n64_480i, vmode, ndeblur, n15bit}
  localparam int demuxparams_width = 6;

  localparam int dp_cnt_lsb   = 4;
  localparam int dp_cnt_width = 2;
  localparam int dp_480i      = 3;
  localparam int dp_vmode     = 2;
  localparam int dp_ndeblur   = 1;
  localparam int dp_n15bit    = 0;

  ////////////////////////////////////////////////////////////////////
  // configuration defaults
  ////////////////////////////////////////////////////////////////////

  // full 21-bit colour until the first vsync edge latches the input
  localparam logic n15bit_rst = 1'b1;

  // blanking flag value that lets colour through
  localparam logic nblank_pass = 1'b1;

endpackage

`default_nettype wire

//--- n64a_video_pkg.sv
`default_nettype none

package n64a_video_pkg;

  // one word on the multiplexed video bus, also one colour channel
  localparam int color_width = 7;

  // sync bits carried in the low nibble of a dsync word
  // bit 2 is nclamp and is passed through untouched
  localparam int sync_width   = 4;
  localparam int sync_nvsync  = 3;
  localparam int sync_nhsync  = 1;
  localparam int sync_ncsync  = 0;

  // parallel video word is {sync, red, green, blue}
  localparam int vdata_co_width = 3 * color_width;
  localparam int vdata_width    = sync_width + vdata_co_width;
  localparam int vdata_sy_lsb   = 3 * color_width;
  localparam int vdata_re_lsb   = 2 * color_width;
  localparam int vdata_gr_lsb   = color_width;
  localparam int vdata_bl_lsb   = 0;

  // low colour bits cleared in reduced colour mode
  localparam int reduced_lsbs = 2;

  // position of the current bus word inside its four word group
  typedef enum logic [1:0] {
    phase_sync  = 2'd0,
    phase_red   = 2'd1,
    phase_green = 2'd2,
    phase_blue  = 2'd3
  } phase_t;

endpackage

`default_nettype wire
